/* Makefile */
VERILATOR ?= verilator
TOP       ?= mips_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/100ps
PASS_TEXT ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* tests/mips_checker.sv */
`default_nettype none

module mips_checker #(
    parameter int ROWS = 1
) (
    input  wire         clk,
    input  wire         reset,
    input  wire         w_grf_we,
    input  wire  [4:0]  w_grf_addr,
    input  wire  [31:0] w_grf_wdata,
    input  wire  [31:0] w_inst_addr,
    input  wire  [4:0]  exp_num,
    input  wire  [31:0] exp_data,
    input  wire  [31:0] exp_pc,
    output int          seen,
    output int          good,
    output int          bad
);
    timeunit 1ns;
    timeprecision 100ps;

    logic row_ok;

    assign row_ok = (w_grf_addr == exp_num) && (w_grf_wdata == exp_data)
                    && (w_inst_addr == exp_pc);

    task automatic compare_field(input int row, input string name,
                                 input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual)
            $display("MISMATCH row %0d %s expected %h got %h", row, name, expected, actual);
    endtask

    // one strobe per register write, compared in program order
    always @(posedge clk) begin
        if (reset) begin
            seen <= 0;
            good <= 0;
            bad  <= 0;
        end else if (w_grf_we) begin
            seen <= seen + 1;
            if (seen >= ROWS) begin
                $display("unexpected register write to $%0d from %h after the last expected row",
                         w_grf_addr, w_inst_addr);
                bad <= bad + 1;
            end else if (row_ok) begin
                $display("row %0d ok: $%0d <= %h from %h", seen, w_grf_addr, w_grf_wdata,
                         w_inst_addr);
                good <= good + 1;
            end else begin
                compare_field(seen, "w_grf_addr", 32'(exp_num), 32'(w_grf_addr));
                compare_field(seen, "w_grf_wdata", exp_data, w_grf_wdata);
                compare_field(seen, "w_inst_addr", exp_pc, w_inst_addr);
                bad <= bad + 1;
            end
        end
    end
endmodule

`default_nettype wire

/* tests/mips_sva.sv */
`include "mips_config.svh"
`default_nettype none

module mips_sva (
    input wire        clk,
    input wire        reset,
    input wire        stall,
    input wire        w_grf_we,
    input wire [3:0]  data_byteen,
    input wire [31:0] data_addr,
    input wire [4:0]  e_rs,
    input wire [4:0]  e_rt,
    input wire [31:0] e_rs_fwd,
    input wire [31:0] e_rt_fwd
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [2:0] since_reset;  // saturating count of edges since reset release

    always @(posedge clk) begin
        if (reset)
            since_reset <= 3'd0;
        else if (since_reset != 3'd7)
            since_reset <= since_reset + 3'd1;
    end

    // first fetch reaches memory after three edges and writeback after four
    quiet_mem: assert property (@(posedge clk) disable iff (reset)
        since_reset < 3'd3 |-> data_byteen == 4'b0000)
        else $error("data_byteen high before a store could reach memory");

    quiet_wb: assert property (@(posedge clk) disable iff (reset)
        since_reset < 3'd4 |-> !w_grf_we)
        else $error("w_grf_we high before an instruction could reach writeback");

    short_stall: assert property (@(posedge clk) disable iff (reset)
        stall && $past(stall) |=> !stall)
        else $error("stall held for more than two cycles");

    // operands after forwarding, so a write to $0 further down must not leak in
    zero_rs: assert property (@(posedge clk) disable iff (reset)
        e_rs == 5'd0 |-> e_rs_fwd == 32'd0)
        else $error("register zero operand nonzero in execute on rs");

    zero_rt: assert property (@(posedge clk) disable iff (reset)
        e_rt == 5'd0 |-> e_rt_fwd == 32'd0)
        else $error("register zero operand nonzero in execute on rt");

    dm_range: assert property (@(posedge clk) disable iff (reset)
        data_byteen != 4'b0000 |-> (data_addr >> 2) < `MIPS_DM_WORDS)
        else $error("store address beyond the data memory");
endmodule

bind mips mips_sva mips_sva_i (
    .clk(clk),
    .reset(reset),
    .stall(stall),
    .w_grf_we(w_grf_we),
    .data_byteen(data_byteen),
    .data_addr(data_addr),
    .e_rs(e_rs),
    .e_rt(e_rt),
    .e_rs_fwd(e_rs_fwd),
    .e_rt_fwd(e_rt_fwd)
);

`default_nettype wire

/* tests/mips_tb.sv */
`include "mips_config.svh"
`default_nettype none

module mips_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PROG_LEN    = 29;
    localparam int N_WRITES    = 23;
    localparam int CYCLE_LIMIT = 5 * PROG_LEN + 50;

    logic        clk = 1'b0;
    logic        reset;
    logic [31:0] inst_rdata;
    logic [31:0] inst_addr;
    logic        w_grf_we;
    logic [4:0]  w_grf_addr;
    logic [31:0] w_grf_wdata;
    logic [31:0] w_inst_addr;
    logic [4:0]  exp_num;
    logic [31:0] exp_data;
    logic [31:0] exp_pc;
    int          seen;
    int          good;
    int          bad;
    int          cycles = 0;
    int          n_prog = 0;
    int          n_exp = 0;

    logic [31:0] program_rom [PROG_LEN];
    logic [4:0]  exp_num_tab [N_WRITES];
    logic [31:0] exp_data_tab [N_WRITES];
    logic [31:0] exp_pc_tab [N_WRITES];

    always #2 clk = ~clk;

    mips_soc mips_soc_i (
        .clk(clk),
        .reset(reset),
        .inst_rdata(inst_rdata),
        .inst_addr(inst_addr),
        .w_grf_we(w_grf_we),
        .w_grf_addr(w_grf_addr),
        .w_grf_wdata(w_grf_wdata),
        .w_inst_addr(w_inst_addr)
    );

    mips_checker #(.ROWS(N_WRITES)) checker_i (
        .clk(clk),
        .reset(reset),
        .w_grf_we(w_grf_we),
        .w_grf_addr(w_grf_addr),
        .w_grf_wdata(w_grf_wdata),
        .w_inst_addr(w_inst_addr),
        .exp_num(exp_num),
        .exp_data(exp_data),
        .exp_pc(exp_pc),
        .seen(seen),
        .good(good),
        .bad(bad)
    );

    function automatic logic [31:0] reg_form(input mips_pkg::funct_e fn, input logic [4:0] rd,
                                             input logic [4:0] rs, input logic [4:0] rt);
        mips_pkg::instr_u word;
        word.r.opcode = mips_pkg::OP_SPECIAL;
        word.r.rs     = rs;
        word.r.rt     = rt;
        word.r.rd     = rd;
        word.r.shamt  = 5'd0;
        word.r.funct  = fn;
        return word;
    endfunction

    function automatic logic [31:0] imm_form(input mips_pkg::opcode_e op, input logic [4:0] rt,
                                             input logic [4:0] rs, input logic [15:0] imm);
        mips_pkg::instr_u word;
        word.i.opcode = op;
        word.i.rs     = rs;
        word.i.rt     = rt;
        word.i.imm    = imm;
        return word;
    endfunction

    function automatic logic [31:0] jump_form(input logic [31:0] target);
        return {mips_pkg::OP_J, target[27:2]};
    endfunction

    // past the end of the table reads as a no-op
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        int idx;
        idx = int'((addr - `MIPS_RESET_PC) >> 2);
        if (addr < `MIPS_RESET_PC || idx >= PROG_LEN)
            return 32'h0;
        return program_rom[idx];
    endfunction

    task automatic add_instr(input logic [31:0] word);
        program_rom[n_prog] = word;
        n_prog++;
    endtask

    // expected write of the instruction added last
    task automatic expect_write(input logic [4:0] num, input logic [31:0] data);
        exp_num_tab[n_exp]  = num;
        exp_data_tab[n_exp] = data;
        exp_pc_tab[n_exp]   = `MIPS_RESET_PC + 32'(4 * (n_prog - 1));
        n_exp++;
    endtask

    task automatic load_program;
        // independent ALU ops with wraparound
        add_instr(imm_form(mips_pkg::OP_ORI, 5'd1, 5'd0, 16'h1234));
        expect_write(5'd1, 32'h0000_1234);
        add_instr(imm_form(mips_pkg::OP_LUI, 5'd2, 5'd0, 16'h8000));
        expect_write(5'd2, 32'h8000_0000);
        add_instr(imm_form(mips_pkg::OP_ORI, 5'd3, 5'd0, 16'hffff));
        expect_write(5'd3, 32'h0000_ffff);
        add_instr(imm_form(mips_pkg::OP_LUI, 5'd4, 5'd0, 16'h8000));
        expect_write(5'd4, 32'h8000_0000);
        add_instr(reg_form(mips_pkg::FN_ADDU, 5'd5, 5'd2, 5'd4));
        expect_write(5'd5, 32'h0000_0000);
        add_instr(reg_form(mips_pkg::FN_SUBU, 5'd6, 5'd0, 5'd1));
        expect_write(5'd6, 32'hffff_edcc);
        // dependency chain at distance 1, 2 and 3
        add_instr(imm_form(mips_pkg::OP_ORI, 5'd7, 5'd0, 16'h0005));
        expect_write(5'd7, 32'd5);
        add_instr(reg_form(mips_pkg::FN_ADDU, 5'd8, 5'd7, 5'd7));
        expect_write(5'd8, 32'd10);
        add_instr(reg_form(mips_pkg::FN_ADDU, 5'd9, 5'd8, 5'd7));
        expect_write(5'd9, 32'd15);
        add_instr(reg_form(mips_pkg::FN_SUBU, 5'd10, 5'd9, 5'd7));
        expect_write(5'd10, 32'd10);
        // store, load, then use at once
        add_instr(imm_form(mips_pkg::OP_ORI, 5'd11, 5'd0, 16'h0010));
        expect_write(5'd11, 32'h0000_0010);
        add_instr(imm_form(mips_pkg::OP_SW, 5'd9, 5'd11, 16'h0004));
        add_instr(imm_form(mips_pkg::OP_LW, 5'd12, 5'd11, 16'h0004));
        expect_write(5'd12, 32'd15);
        add_instr(reg_form(mips_pkg::FN_ADDU, 5'd13, 5'd12, 5'd1));
        expect_write(5'd13, 32'h0000_1243);
        // taken beq on a value one instruction old
        add_instr(imm_form(mips_pkg::OP_ORI, 5'd14, 5'd0, 16'h000f));
        expect_write(5'd14, 32'd15);
        add_instr(imm_form(mips_pkg::OP_BEQ, 5'd12, 5'd14, 16'h0002));
        add_instr(imm_form(mips_pkg::OP_ORI, 5'd15, 5'd0, 16'h0077));
        expect_write(5'd15, 32'h0000_0077);
        add_instr(imm_form(mips_pkg::OP_ORI, 5'd16, 5'd0, 16'h0bad));  // skipped
        add_instr(reg_form(mips_pkg::FN_ADDU, 5'd17, 5'd14, 5'd15));
        expect_write(5'd17, 32'h0000_0086);
        // beq not taken right behind a load
        add_instr(imm_form(mips_pkg::OP_LW, 5'd18, 5'd11, 16'h0004));
        expect_write(5'd18, 32'd15);
        add_instr(imm_form(mips_pkg::OP_BEQ, 5'd1, 5'd18, 16'h0002));
        add_instr(imm_form(mips_pkg::OP_ORI, 5'd19, 5'd0, 16'h0021));
        expect_write(5'd19, 32'h0000_0021);
        add_instr(imm_form(mips_pkg::OP_ORI, 5'd20, 5'd0, 16'h0022));
        expect_write(5'd20, 32'h0000_0022);
        add_instr(jump_form(`MIPS_RESET_PC + 32'h68));
        add_instr(imm_form(mips_pkg::OP_ORI, 5'd21, 5'd0, 16'h0024));
        expect_write(5'd21, 32'h0000_0024);
        add_instr(imm_form(mips_pkg::OP_ORI, 5'd22, 5'd0, 16'h0025));  // skipped
        // jump target, register zero written then read
        add_instr(reg_form(mips_pkg::FN_ADDU, 5'd0, 5'd1, 5'd1));
        expect_write(5'd0, 32'h0000_2468);
        add_instr(reg_form(mips_pkg::FN_ADDU, 5'd23, 5'd0, 5'd1));
        expect_write(5'd23, 32'h0000_1234);
        add_instr(reg_form(mips_pkg::FN_SUBU, 5'd24, 5'd1, 5'd0));
        expect_write(5'd24, 32'h0000_1234);
    endtask

    task automatic print_counts;
        $display("%0d of %0d writes matched, %0d failed", good, N_WRITES, bad);
    endtask

    always @(negedge clk)
        inst_rdata <= fetch_word(inst_addr);

    always @(posedge clk) begin
        if (!reset)
            cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("timeout: only %0d of %0d register writes seen after %0d cycles",
                     seen, N_WRITES, cycles);
            print_counts();
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        reset      = 1'b1;
        inst_rdata = 32'h0;
        exp_num    = 5'd0;
        exp_data   = 32'h0;
        exp_pc     = 32'h0;
        load_program();
        repeat (5) @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < N_WRITES; i++) begin
            exp_num  = exp_num_tab[i];
            exp_data = exp_data_tab[i];
            exp_pc   = exp_pc_tab[i];
            while (seen == i)
                @(negedge clk);
        end
        repeat (8) @(negedge clk);  // room for stray writes
        print_counts();
        if (bad == 0 && good == N_WRITES)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end
endmodule

`default_nettype wire

/* verilog.f */
+incdir+verilog
verilog/mips_pkg.sv
verilog/mips_decode.sv
verilog/mips_hazard.sv
verilog/mips_grf.sv
verilog/mips.sv
verilog/mips_soc.sv
tests/mips_checker.sv
tests/mips_sva.sv
tests/mips_tb.sv

/* verilog/mips.sv */
`include "mips_config.svh"
`default_nettype none

module mips (
    input  wire         clk,
    input  wire         reset,
    input  wire  [31:0] inst_rdata,
    input  wire  [31:0] data_rdata,
    output logic [31:0] inst_addr,
    output logic [31:0] data_addr,
    output logic [31:0] data_wdata,
    output logic [3:0]  data_byteen,
    output logic        w_grf_we,
    output logic [4:0]  w_grf_addr,
    output logic [31:0] w_grf_wdata,
    output logic [31:0] w_inst_addr
);
    logic [31:0] pc_f, pc_next;
    logic        stall;

    mips_pkg::instr_u   d_instr;
    mips_pkg::alu_op_e  d_alu_op, e_alu_op;
    mips_pkg::imm_sel_e d_imm_sel;
    mips_pkg::res_src_e d_res_src, e_res_src, m_res_src, w_res_src;
    mips_pkg::fwd_e     fwd_d_rs, fwd_d_rt, fwd_e_rs, fwd_e_rt, fwd_m_rt;
    logic [31:0] d_pc, d_pc4, d_rs_raw, d_rt_raw, d_rs_val, d_rt_val, d_imm;
    logic        d_we, d_mem_we, d_is_beq, d_is_jump;
    logic [4:0]  d_dst;
    logic [`MIPS_T_BITS-1:0] d_tuse_rs, d_tuse_rt, d_tnew, e_tnew, m_tnew;

    logic        e_we, e_mem_we, e_use_imm;
    logic [4:0]  e_dst, e_rs, e_rt;
    logic [31:0] e_pc, e_rs_val, e_rt_val, e_imm, e_rs_fwd, e_rt_fwd, e_alu_b, e_alu;

    logic        m_we, m_mem_we;
    logic [4:0]  m_dst, m_rt;
    logic [31:0] m_pc, m_alu, m_rt_val, m_rt_fwd, m_fwd_data;

    logic        w_we;
    logic [4:0]  w_dst;
    logic [31:0] w_pc, w_alu, w_mem, w_wdata;

    function automatic logic [31:0] fwd_mux(input mips_pkg::fwd_e sel, input logic [31:0] raw);
        case (sel)
            mips_pkg::FWD_E: return e_pc + 32'd8;  // only pc8 results are ready in E
            mips_pkg::FWD_M: return m_fwd_data;
            mips_pkg::FWD_W: return w_wdata;
            default:         return raw;
        endcase
    endfunction

    assign inst_addr = pc_f;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_f    <= `MIPS_RESET_PC;
            d_instr <= '0;  // sll $0 bubble
        end else if (!stall) begin
            pc_f    <= pc_next;
            d_instr <= inst_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall)
            d_pc <= pc_f;
    end

    mips_decode decode_i (
        .instr(d_instr), .alu_op(d_alu_op), .imm_sel(d_imm_sel), .res_src(d_res_src),
        .reg_we(d_we), .reg_dst(d_dst), .mem_we(d_mem_we), .is_beq(d_is_beq),
        .is_jump(d_is_jump), .tuse_rs(d_tuse_rs), .tuse_rt(d_tuse_rt), .tnew(d_tnew)
    );

    mips_grf grf_i (
        .clk(clk), .reset(reset), .rd_num1(d_instr.r.rs), .rd_num2(d_instr.r.rt),
        .wr_num(w_dst), .wr_en(w_we), .wr_data(w_wdata),
        .rd_data1(d_rs_raw), .rd_data2(d_rt_raw)
    );

    mips_hazard hazard_i (
        .d_rs(d_instr.r.rs), .d_rt(d_instr.r.rt), .d_tuse_rs(d_tuse_rs), .d_tuse_rt(d_tuse_rt),
        .e_dst(e_dst), .e_we(e_we), .e_tnew(e_tnew), .m_dst(m_dst), .m_we(m_we),
        .m_tnew(m_tnew), .w_dst(w_dst), .w_we(w_we), .e_rs(e_rs), .e_rt(e_rt), .m_rt(m_rt),
        .stall(stall), .fwd_d_rs(fwd_d_rs), .fwd_d_rt(fwd_d_rt), .fwd_e_rs(fwd_e_rs),
        .fwd_e_rt(fwd_e_rt), .fwd_m_rt(fwd_m_rt)
    );

    always_comb begin
        d_rs_val = fwd_mux(fwd_d_rs, d_rs_raw);
        d_rt_val = fwd_mux(fwd_d_rt, d_rt_raw);
        e_rs_fwd = fwd_mux(fwd_e_rs, e_rs_val);
        e_rt_fwd = fwd_mux(fwd_e_rt, e_rt_val);
        m_rt_fwd = fwd_mux(fwd_m_rt, m_rt_val);
    end

    always_comb begin
        case (d_imm_sel)
            mips_pkg::IMM_ZERO:  d_imm = {16'h0, d_instr.i.imm};
            mips_pkg::IMM_UPPER: d_imm = {d_instr.i.imm, 16'h0};
            default:             d_imm = {{16{d_instr.i.imm[15]}}, d_instr.i.imm};
        endcase
    end

    // branch and jump resolve here, the delay slot is already in fetch
    assign d_pc4 = d_pc + 32'd4;
    always_comb begin
        if (d_is_beq && d_rs_val == d_rt_val)
            pc_next = d_pc4 + {d_imm[29:0], 2'b00};
        else if (d_is_jump)
            pc_next = {d_pc4[31:28], d_instr[25:0], 2'b00};
        else
            pc_next = pc_f + 32'd4;
    end

    always_ff @(posedge clk) begin
        if (reset || stall) begin
            e_we     <= 1'b0;  // bubble
            e_mem_we <= 1'b0;
            e_dst    <= 5'd0;
            e_tnew   <= '0;
        end else begin
            e_we     <= d_we;
            e_mem_we <= d_mem_we;
            e_dst    <= d_dst;
            e_tnew   <= d_tnew;
        end
    end

    always_ff @(posedge clk) begin
        e_alu_op  <= d_alu_op;
        e_res_src <= d_res_src;
        e_use_imm <= d_instr.r.opcode != mips_pkg::OP_SPECIAL;
        e_pc      <= d_pc;
        e_rs      <= d_instr.r.rs;
        e_rt      <= d_instr.r.rt;
        e_rs_val  <= d_rs_val;
        e_rt_val  <= d_rt_val;
        e_imm     <= d_imm;
    end

    always_comb begin
        e_alu_b = e_use_imm ? e_imm : e_rt_fwd;
        case (e_alu_op)
            mips_pkg::ALU_ADD: e_alu = e_rs_fwd + e_alu_b;
            mips_pkg::ALU_SUB: e_alu = e_rs_fwd - e_alu_b;
            mips_pkg::ALU_OR:  e_alu = e_rs_fwd | e_alu_b;
            default:           e_alu = e_alu_b;  // lui, already shifted
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            m_we     <= 1'b0;
            m_mem_we <= 1'b0;
            m_dst    <= 5'd0;
            m_tnew   <= '0;
        end else begin
            m_we     <= e_we;
            m_mem_we <= e_mem_we;
            m_dst    <= e_dst;
            m_tnew   <= (e_tnew == '0) ? '0 : e_tnew - `MIPS_T_BITS'(1);
        end
    end

    always_ff @(posedge clk) begin
        m_res_src <= e_res_src;
        m_pc      <= e_pc;
        m_alu     <= e_alu;
        m_rt      <= e_rt;
        m_rt_val  <= e_rt_fwd;
    end

    assign m_fwd_data  = (m_res_src == mips_pkg::RES_PC8) ? m_pc + 32'd8 : m_alu;
    assign data_addr   = m_alu;
    assign data_wdata  = m_rt_fwd;
    assign data_byteen = m_mem_we ? 4'b1111 : 4'b0000;  // word stores only

    always_ff @(posedge clk) begin
        if (reset) begin
            w_we  <= 1'b0;
            w_dst <= 5'd0;
        end else begin
            w_we  <= m_we;
            w_dst <= m_dst;
        end
    end

    always_ff @(posedge clk) begin
        w_res_src <= m_res_src;
        w_pc      <= m_pc;
        w_alu     <= m_alu;
        w_mem     <= data_rdata;
    end

    always_comb begin
        case (w_res_src)
            mips_pkg::RES_MEM: w_wdata = w_mem;
            mips_pkg::RES_PC8: w_wdata = w_pc + 32'd8;
            default:           w_wdata = w_alu;
        endcase
    end

    assign w_grf_we    = w_we;
    assign w_grf_addr  = w_dst;
    assign w_grf_wdata = w_wdata;
    assign w_inst_addr = w_pc;
endmodule

`default_nettype wire

/* verilog/mips_config.svh */
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

`define MIPS_RESET_PC   32'h0000_3000
`define MIPS_DM_WORDS   1024
`define MIPS_T_BITS     2

// cycles before an operand is consumed, counted from decode
`define MIPS_TUSE_BRANCH  `MIPS_T_BITS'(0)
`define MIPS_TUSE_ALU     `MIPS_T_BITS'(1)
`define MIPS_TUSE_STORE   `MIPS_T_BITS'(2)
`define MIPS_TUSE_NONE    `MIPS_T_BITS'(3)  // operand never read
// cycles until the result exists, seen from execute
`define MIPS_TNEW_ALU     `MIPS_T_BITS'(1)
`define MIPS_TNEW_LOAD    `MIPS_T_BITS'(2)

`endif

/* verilog/mips_decode.sv */
`include "mips_config.svh"
`default_nettype none

module mips_decode (
    input  wire mips_pkg::instr_u    instr,
    output mips_pkg::alu_op_e        alu_op,
    output mips_pkg::imm_sel_e       imm_sel,
    output mips_pkg::res_src_e       res_src,
    output logic                     reg_we,
    output logic [4:0]               reg_dst,
    output logic                     mem_we,
    output logic                     is_beq,
    output logic                     is_jump,
    output logic [`MIPS_T_BITS-1:0]  tuse_rs,
    output logic [`MIPS_T_BITS-1:0]  tuse_rt,
    output logic [`MIPS_T_BITS-1:0]  tnew
);
    always_comb begin
        // defaults form a no-op
        alu_op  = mips_pkg::ALU_ADD;
        imm_sel = mips_pkg::IMM_SIGN;
        res_src = mips_pkg::RES_ALU;
        reg_we  = 1'b0;
        reg_dst = 5'd0;
        mem_we  = 1'b0;
        is_beq  = 1'b0;
        is_jump = 1'b0;
        tuse_rs = `MIPS_TUSE_NONE;
        tuse_rt = `MIPS_TUSE_NONE;
        tnew    = '0;
        case (instr.r.opcode)
            mips_pkg::OP_SPECIAL: begin
                if (instr.r.funct == mips_pkg::FN_ADDU || instr.r.funct == mips_pkg::FN_SUBU) begin
                    if (instr.r.funct == mips_pkg::FN_SUBU)
                        alu_op = mips_pkg::ALU_SUB;
                    reg_we  = 1'b1;
                    reg_dst = instr.r.rd;
                    tuse_rs = `MIPS_TUSE_ALU;
                    tuse_rt = `MIPS_TUSE_ALU;
                    tnew    = `MIPS_TNEW_ALU;
                end
            end
            mips_pkg::OP_ORI, mips_pkg::OP_LUI: begin
                alu_op  = (instr.i.opcode == mips_pkg::OP_ORI) ? mips_pkg::ALU_OR
                                                                : mips_pkg::ALU_LUI;
                imm_sel = (instr.i.opcode == mips_pkg::OP_ORI) ? mips_pkg::IMM_ZERO
                                                                : mips_pkg::IMM_UPPER;
                reg_we  = 1'b1;
                reg_dst = instr.i.rt;
                tnew    = `MIPS_TNEW_ALU;
                if (instr.i.opcode == mips_pkg::OP_ORI)
                    tuse_rs = `MIPS_TUSE_ALU;  // lui ignores rs
            end
            mips_pkg::OP_LW: begin
                res_src = mips_pkg::RES_MEM;
                reg_we  = 1'b1;
                reg_dst = instr.i.rt;
                tuse_rs = `MIPS_TUSE_ALU;
                tnew    = `MIPS_TNEW_LOAD;
            end
            mips_pkg::OP_SW: begin
                mem_we  = 1'b1;
                tuse_rs = `MIPS_TUSE_ALU;  // address
                tuse_rt = `MIPS_TUSE_STORE;  // store data, needed in memory
            end
            mips_pkg::OP_BEQ: begin
                is_beq  = 1'b1;
                tuse_rs = `MIPS_TUSE_BRANCH;
                tuse_rt = `MIPS_TUSE_BRANCH;
            end
            mips_pkg::OP_J: is_jump = 1'b1;
            default: ;
        endcase
    end
endmodule

`default_nettype wire

/* verilog/mips_grf.sv */
`default_nettype none

module mips_grf (
    input  wire         clk,
    input  wire         reset,
    input  wire  [4:0]  rd_num1,
    input  wire  [4:0]  rd_num2,
    input  wire  [4:0]  wr_num,
    input  wire         wr_en,
    input  wire  [31:0] wr_data,
    output logic [31:0] rd_data1,
    output logic [31:0] rd_data2
);
    logic [31:0] regs [32];

    function automatic logic [31:0] read_port(input logic [4:0] num);
        if (num == 5'd0)
            return '0;
        if (wr_en && wr_num == num)
            return wr_data;  // same-cycle write-through
        return regs[num];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < 32; k++)
                regs[k] <= '0;
        end else if (wr_en && wr_num != 5'd0) begin
            regs[wr_num] <= wr_data;
        end
    end

    always_comb begin
        rd_data1 = read_port(rd_num1);
        rd_data2 = read_port(rd_num2);
    end
endmodule

`default_nettype wire

/* verilog/mips_hazard.sv */
`include "mips_config.svh"
`default_nettype none

module mips_hazard (
    input  wire [4:0]               d_rs,
    input  wire [4:0]               d_rt,
    input  wire [`MIPS_T_BITS-1:0]  d_tuse_rs,
    input  wire [`MIPS_T_BITS-1:0]  d_tuse_rt,
    input  wire [4:0]               e_dst,
    input  wire                     e_we,
    input  wire [`MIPS_T_BITS-1:0]  e_tnew,
    input  wire [4:0]               m_dst,
    input  wire                     m_we,
    input  wire [`MIPS_T_BITS-1:0]  m_tnew,
    input  wire [4:0]               w_dst,
    input  wire                     w_we,
    input  wire [4:0]               e_rs,
    input  wire [4:0]               e_rt,
    input  wire [4:0]               m_rt,
    output logic                    stall,
    output mips_pkg::fwd_e          fwd_d_rs,
    output mips_pkg::fwd_e          fwd_d_rt,
    output mips_pkg::fwd_e          fwd_e_rs,
    output mips_pkg::fwd_e          fwd_e_rt,
    output mips_pkg::fwd_e          fwd_m_rt
);
    // nearest producer decides, older stages are stale
    function automatic logic need_stall(input logic [4:0] num,
                                        input logic [`MIPS_T_BITS-1:0] tuse);
        if (num == 5'd0)
            return 1'b0;
        if (e_we && e_dst == num)
            return e_tnew > tuse;
        if (m_we && m_dst == num)
            return m_tnew > tuse;
        return 1'b0;
    endfunction

    function automatic mips_pkg::fwd_e pick(input logic [4:0] num, input logic from_e,
                                            input logic from_m, input logic from_w);
        if (num == 5'd0)
            return mips_pkg::FWD_NONE;
        if (from_e && e_we && e_dst == num)
            return (e_tnew == '0) ? mips_pkg::FWD_E : mips_pkg::FWD_NONE;
        if (from_m && m_we && m_dst == num)
            return (m_tnew == '0) ? mips_pkg::FWD_M : mips_pkg::FWD_NONE;
        if (from_w && w_we && w_dst == num)
            return mips_pkg::FWD_W;
        return mips_pkg::FWD_NONE;
    endfunction

    always_comb begin
        stall    = need_stall(d_rs, d_tuse_rs) || need_stall(d_rt, d_tuse_rt);
        fwd_d_rs = pick(d_rs, 1'b1, 1'b1, 1'b0);  // writeback covered by the grf
        fwd_d_rt = pick(d_rt, 1'b1, 1'b1, 1'b0);
        fwd_e_rs = pick(e_rs, 1'b0, 1'b1, 1'b1);
        fwd_e_rt = pick(e_rt, 1'b0, 1'b1, 1'b1);
        fwd_m_rt = pick(m_rt, 1'b0, 1'b0, 1'b1);
    end
endmodule

`default_nettype wire

/* verilog/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23
    } funct_e;

    // one word, register form or immediate form
    typedef union packed {
        struct packed {
            opcode_e     opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [4:0]  rd;
            logic [4:0]  shamt;
            funct_e      funct;
        } r;
        struct packed {
            opcode_e     opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
    } instr_u;

    typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_OR, ALU_LUI} alu_op_e;
    typedef enum logic [1:0] {IMM_ZERO, IMM_SIGN, IMM_UPPER} imm_sel_e;
    typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_PC8} res_src_e;
    typedef enum logic [1:0] {FWD_NONE, FWD_E, FWD_M, FWD_W} fwd_e;

endpackage

`default_nettype wire

/* verilog/mips_soc.sv */
`include "mips_config.svh"
`default_nettype none

module mips_soc (
    input  wire         clk,
    input  wire         reset,
    input  wire  [31:0] inst_rdata,
    output logic [31:0] inst_addr,
    output logic        w_grf_we,
    output logic [4:0]  w_grf_addr,
    output logic [31:0] w_grf_wdata,
    output logic [31:0] w_inst_addr
);
    localparam int DM_AW = $clog2(`MIPS_DM_WORDS);

    logic [31:0]      dm [`MIPS_DM_WORDS];
    logic [31:0]      data_addr, data_wdata, data_rdata;
    logic [3:0]       data_byteen;
    logic [DM_AW-1:0] dm_index;

    assign dm_index   = data_addr[DM_AW+1:2];  // word address
    assign data_rdata = dm[dm_index];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < `MIPS_DM_WORDS; k++)
                dm[k] <= '0;
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (data_byteen[b])
                    dm[dm_index][8*b +: 8] <= data_wdata[8*b +: 8];
            end
        end
    end

    mips mips_i (
        .clk(clk),
        .reset(reset),
        .inst_rdata(inst_rdata),
        .data_rdata(data_rdata),
        .inst_addr(inst_addr),
        .data_addr(data_addr),
        .data_wdata(data_wdata),
        .data_byteen(data_byteen),
        .w_grf_we(w_grf_we),
        .w_grf_addr(w_grf_addr),
        .w_grf_wdata(w_grf_wdata),
        .w_inst_addr(w_inst_addr)
    );
endmodule

`default_nettype wire
